//--- filelist.f
+incdir+source
source/eth_frame_pkg.sv
source/stat_pkg.sv
source/frame_fifo.sv
source/stat_arb_mux.sv
source/stat_counters.sv
source/fpga_core.sv
tests/tb_fpga_core.sv

//--- Makefile
# Verilator build and run for the loopback core testbench

VERILATOR ?= verilator
TOP       ?= tb_fpga_core
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= ALL CHECKS PASSED
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/tb_fpga_core.sv
// Loopback core testbench
`timescale 1ns/1ps
`default_nettype none

`include "eth_core_macros.svh"

module tb_fpga_core;
    import eth_frame_pkg::*;
    import stat_pkg::*;

    localparam int NCNT        = `PORT_CNT * `STAT_KIND_CNT;
    // Rough length of all tests in clock cycles
    localparam int TEST_CYCLES = 2000;

    logic                 clk_125mhz = 1'b0;
    logic                 arst_n_i;
    logic [`PORT_CNT-1:0] rx_valid_i;
    axis_beat_t           rx_beat_i [`PORT_CNT];
    logic [`PORT_CNT-1:0] tx_valid_o;
    axis_beat_t           tx_beat_o [`PORT_CNT];
    logic [`PORT_CNT-1:0] tx_ready_i = '1;
    logic                 stat_rd_en_i;
    stat_id_t             stat_rd_addr_i;
    logic                 stat_rd_valid_o;
    stat_count_t          stat_rd_data_o;

    integer      seed = 39;
    logic        rand_ready;
    logic        ready_level;
    axis_beat_t  exp_q [`PORT_CNT][$];
    stat_count_t cnt_model [NCNT];

    fpga_core dut (
        .clk_125mhz     (clk_125mhz),
        .arst_n_i       (arst_n_i),
        .rx_valid_i     (rx_valid_i),
        .rx_beat_i      (rx_beat_i),
        .tx_valid_o     (tx_valid_o),
        .tx_beat_o      (tx_beat_o),
        .tx_ready_i     (tx_ready_i),
        .stat_rd_en_i   (stat_rd_en_i),
        .stat_rd_addr_i (stat_rd_addr_i),
        .stat_rd_valid_o(stat_rd_valid_o),
        .stat_rd_data_o (stat_rd_data_o)
    );

    always #10 clk_125mhz = ~clk_125mhz;

    // Ready is held at a level or random per cycle
    always @(posedge clk_125mhz) begin
        logic [31:0] rnd;
        rnd = $random(seed);
        if (rand_ready) begin
            tx_ready_i <= rnd[`PORT_CNT-1:0];
        end else begin
            tx_ready_i <= {`PORT_CNT{ready_level}};
        end
    end

    task automatic check_beat(input int port, input axis_beat_t got, input axis_beat_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: port %0d beat %02h/%0b/%0b, expected %02h/%0b/%0b",
                     $time, port, got.data, got.last, got.user, exp.data, exp.last, exp.user);
            $display("CHECKS FAILED");
            $fatal(1, "tx beat mismatch");
        end
    endtask

    task automatic check_count(input stat_id_t id, input stat_count_t got,
                               input stat_count_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: counter %0d reads %0d, expected %0d",
                     $time, id, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "counter mismatch");
        end
    endtask

    // Transfer happens at the next rising edge, so compare at the falling one
    always @(negedge clk_125mhz) begin
        for (int p = 0; p < `PORT_CNT; p++) begin
            if (arst_n_i && tx_valid_o[p] && tx_ready_i[p]) begin
                if (exp_q[p].size() == 0) begin
                    $display("Port %0d sent a beat that belongs to no expected frame", p);
                    $display("CHECKS FAILED");
                    $fatal(1, "unexpected tx beat");
                end else begin
                    check_beat(p, tx_beat_o[p], exp_q[p].pop_front());
                end
            end
        end
    end

    function automatic int pending_beats();
        int n;
        n = 0;
        for (int p = 0; p < `PORT_CNT; p++) begin
            n += exp_q[p].size();
        end
        return n;
    endfunction

    // One frame per port, all starting together
    // Zero length leaves a port idle
    task automatic send_burst(input logic [`PORT_CNT-1:0][7:0] lens,
                              input logic [`PORT_CNT-1:0] bad,
                              input logic [`PORT_CNT-1:0] drop);
        int         max_len;
        int         idx;
        axis_beat_t beat;
        max_len = 0;
        for (int p = 0; p < `PORT_CNT; p++) begin
            if (int'(lens[p]) > max_len) begin
                max_len = int'(lens[p]);
            end
        end
        for (int i = 0; i < max_len; i++) begin
            @(posedge clk_125mhz);
            for (int p = 0; p < `PORT_CNT; p++) begin
                beat.data = byte_t'($random(seed));
                beat.last = (i == int'(lens[p]) - 1);
                beat.user = beat.last && bad[p];
                rx_valid_i[p] <= (i < int'(lens[p]));
                rx_beat_i[p]  <= beat;
                if (i < int'(lens[p]) && !bad[p] && !drop[p]) begin
                    exp_q[p].push_back(beat);
                end
            end
        end
        @(posedge clk_125mhz);
        rx_valid_i <= '0;
        // Expected statistics of this burst
        for (int p = 0; p < `PORT_CNT; p++) begin
            idx = p * `STAT_KIND_CNT;
            if (lens[p] == 8'd0) begin
                continue;
            end
            if (bad[p]) begin
                cnt_model[idx + int'(KIND_BAD_PKT)] += 1;
            end else if (drop[p]) begin
                cnt_model[idx + int'(KIND_DROP_PKT)] += 1;
            end else begin
                cnt_model[idx + int'(KIND_GOOD_PKT)]  += 1;
                cnt_model[idx + int'(KIND_GOOD_BYTE)] += stat_count_t'(lens[p]);
            end
        end
    endtask

    task automatic wait_drain(input int limit);
        int cycles;
        cycles = 0;
        while (pending_beats() != 0 && cycles < limit) begin
            @(negedge clk_125mhz);
            cycles++;
        end
        if (pending_beats() != 0) begin
            $display("Frames did not leave tx within %0d cycles, %0d beats missing",
                     limit, pending_beats());
            $display("CHECKS FAILED");
            $fatal(1, "tx drain timeout");
        end
    endtask

    // Response comes one cycle after the strobe and lasts one cycle
    task automatic read_counter(input stat_id_t id, output stat_count_t value);
        @(posedge clk_125mhz);
        stat_rd_en_i   <= 1'b1;
        stat_rd_addr_i <= id;
        @(posedge clk_125mhz);
        stat_rd_en_i <= 1'b0;
        @(negedge clk_125mhz);
        if (!stat_rd_valid_o) begin
            $display("Read of counter %0d got no valid response one cycle after the strobe",
                     id);
            $display("CHECKS FAILED");
            $fatal(1, "counter read timeout");
        end else begin
            value = stat_rd_data_o;
            @(negedge clk_125mhz);
            if (stat_rd_valid_o) begin
                $display("Read of counter %0d kept its valid response longer than one cycle",
                         id);
                $display("CHECKS FAILED");
                $fatal(1, "counter read valid too long");
            end
        end
    endtask

    // Idle gap lets pending increments reach the counters
    task automatic check_counters();
        stat_count_t value;
        repeat (40) @(posedge clk_125mhz);
        for (int id = 0; id < NCNT; id++) begin
            read_counter(stat_id_t'(id), value);
            check_count(stat_id_t'(id), value, cnt_model[id]);
        end
    endtask

    task automatic loopback_frames();
        logic [`PORT_CNT-1:0][7:0] lens;
        send_burst({8'd20, 8'd13, 8'd7, 8'd1}, '0, '0);
        repeat (2) begin
            for (int p = 0; p < `PORT_CNT; p++) begin
                lens[p] = 8'(1 + $unsigned($random(seed)) % 20);
            end
            send_burst(lens, '0, '0);
        end
        wait_drain(200);
        check_counters();
    endtask

    task automatic bad_frame_drop();
        send_burst({8'd9, 8'd5, 8'd14, 8'd3}, '0, '0);
        send_burst({8'd6, 8'd11, 8'd2, 8'd17}, 4'b0110, '0);
        send_burst({8'd4, 8'd19, 8'd8, 8'd12}, '0, '0);
        wait_drain(200);
        check_counters();
    endtask

    // Three 20 byte frames fit, the two after them do not
    task automatic overflow_drop();
        ready_level <= 1'b0;
        for (int f = 0; f < 5; f++) begin
            send_burst({`PORT_CNT{8'd20}}, '0, (f >= 3) ? '1 : '0);
        end
        repeat (10) @(posedge clk_125mhz);
        ready_level <= 1'b1;
        wait_drain(300);
        check_counters();
    endtask

    task automatic concurrent_stats();
        for (int f = 0; f < 3; f++) begin
            send_burst({`PORT_CNT{8'd8}}, '0, '0);
        end
        send_burst({`PORT_CNT{8'd5}}, 4'b1010, '0);
        send_burst({`PORT_CNT{8'd16}}, '0, '0);
        wait_drain(200);
        check_counters();
    endtask

    // At most 56 bytes per port, below the FIFO depth
    task automatic random_backpressure();
        logic [`PORT_CNT-1:0][7:0] lens;
        rand_ready <= 1'b1;
        for (int f = 0; f < 4; f++) begin
            for (int p = 0; p < `PORT_CNT; p++) begin
                lens[p] = 8'(1 + $unsigned($random(seed)) % 14);
            end
            send_burst(lens, '0, '0);
        end
        wait_drain(600);
        rand_ready <= 1'b0;
        check_counters();
    endtask

    initial begin
        arst_n_i       <= 1'b0;
        rx_valid_i     <= '0;
        stat_rd_en_i   <= 1'b0;
        stat_rd_addr_i <= '0;
        rand_ready     <= 1'b0;
        ready_level    <= 1'b1;
        for (int p = 0; p < `PORT_CNT; p++) begin
            rx_beat_i[p] <= '0;
        end
        for (int i = 0; i < NCNT; i++) begin
            cnt_model[i] = '0;
        end
        repeat (8) @(posedge clk_125mhz);
        arst_n_i <= 1'b1;
        loopback_frames();
        bad_frame_drop();
        overflow_drop();
        concurrent_stats();
        random_backpressure();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 20 * 4);
        $display("Simulation ran past its time limit");
        $display("CHECKS FAILED");
        $fatal(1, "watchdog timeout");
    end

endmodule

`default_nettype wire

//--- source/fpga_core.sv
// Ethernet loopback core
`timescale 1ns/1ps
`default_nettype none

`include "eth_core_macros.svh"

module fpga_core (
    input  wire logic                      clk_125mhz,
    input  wire logic                      arst_n_i,
    input  wire logic [`PORT_CNT-1:0]      rx_valid_i,
    input  wire eth_frame_pkg::axis_beat_t rx_beat_i [`PORT_CNT],
    output wire logic [`PORT_CNT-1:0]      tx_valid_o,
    output wire eth_frame_pkg::axis_beat_t tx_beat_o [`PORT_CNT],
    input  wire logic [`PORT_CNT-1:0]      tx_ready_i,
    input  wire logic                      stat_rd_en_i,
    input  wire stat_pkg::stat_id_t        stat_rd_addr_i,
    output wire logic                      stat_rd_valid_o,
    output wire stat_pkg::stat_count_t     stat_rd_data_o
);
    import stat_pkg::*;

    logic [`PORT_CNT-1:0] fifo_stat_valid;
    logic [`PORT_CNT-1:0] fifo_stat_ready;
    stat_inc_t            fifo_stat_inc [`PORT_CNT];
    logic                 arb_valid;
    stat_inc_t            arb_inc;

    // One loopback FIFO per port
    for (genvar p = 0; p < `PORT_CNT; p++) begin : g_port
        frame_fifo #(
            .DEPTH(`FIFO_DEPTH)
        ) u_fifo (
            .clk_125mhz  (clk_125mhz),
            .arst_n_i    (arst_n_i),
            .s_valid_i   (rx_valid_i[p]),
            .s_beat_i    (rx_beat_i[p]),
            .m_valid_o   (tx_valid_o[p]),
            .m_beat_o    (tx_beat_o[p]),
            .m_ready_i   (tx_ready_i[p]),
            .port_id_i   (port_id_t'(p)),
            .stat_valid_o(fifo_stat_valid[p]),
            .stat_inc_o  (fifo_stat_inc[p]),
            .stat_ready_i(fifo_stat_ready[p])
        );
    end

    stat_arb_mux u_stat_arb (
        .clk_125mhz(clk_125mhz),
        .arst_n_i  (arst_n_i),
        .s_valid_i (fifo_stat_valid),
        .s_inc_i   (fifo_stat_inc),
        .s_ready_o (fifo_stat_ready),
        .m_valid_o (arb_valid),
        .m_inc_o   (arb_inc)
    );

    stat_counters u_stat_cnt (
        .clk_125mhz (clk_125mhz),
        .arst_n_i   (arst_n_i),
        .inc_valid_i(arb_valid),
        .inc_i      (arb_inc),
        .rd_en_i    (stat_rd_en_i),
        .rd_addr_i  (stat_rd_addr_i),
        .rd_valid_o (stat_rd_valid_o),
        .rd_data_o  (stat_rd_data_o)
    );

endmodule

`default_nettype wire

//--- source/stat_counters.sv
// Statistics counter bank
`timescale 1ns/1ps
`default_nettype none

`include "eth_core_macros.svh"

module stat_counters (
    input  wire logic                clk_125mhz,
    input  wire logic                arst_n_i,
    input  wire logic                inc_valid_i,
    input  wire stat_pkg::stat_inc_t inc_i,
    input  wire logic                rd_en_i,
    input  wire stat_pkg::stat_id_t  rd_addr_i,
    output logic                     rd_valid_o,
    output stat_pkg::stat_count_t    rd_data_o
);
    import stat_pkg::*;

    localparam int COUNTER_CNT = `PORT_CNT * `STAT_KIND_CNT;

    stat_count_t cnt_q [COUNTER_CNT];

    // Counters wrap at full scale
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < COUNTER_CNT; i++) begin
                cnt_q[i] <= '0;
            end
        end else if (inc_valid_i) begin
            cnt_q[inc_i.id] <= cnt_q[inc_i.id] + stat_count_t'(inc_i.inc);
        end
    end

    // Read returns the value before any update in the same cycle
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (rd_en_i) begin
            rd_data_o <= cnt_q[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

//--- source/stat_arb_mux.sv
// Round robin statistics merge
`timescale 1ns/1ps
`default_nettype none

`include "eth_core_macros.svh"

module stat_arb_mux (
    input  wire logic                 clk_125mhz,
    input  wire logic                 arst_n_i,
    input  wire logic [`PORT_CNT-1:0] s_valid_i,
    input  wire stat_pkg::stat_inc_t  s_inc_i [`PORT_CNT],
    output logic [`PORT_CNT-1:0]      s_ready_o,
    output logic                      m_valid_o,
    output stat_pkg::stat_inc_t       m_inc_o
);
    import stat_pkg::*;

    port_id_t last_q;
    port_id_t grant_idx;
    logic     grant_hit;

    // Search starts one past the last granted port
    always_comb begin
        port_id_t cand;
        grant_idx = last_q;
        grant_hit = 1'b0;
        for (int i = 1; i <= `PORT_CNT; i++) begin
            cand = port_id_t'((int'(last_q) + i) % `PORT_CNT);
            if (!grant_hit && s_valid_i[cand]) begin
                grant_idx = cand;
                grant_hit = 1'b1;
            end
        end
    end

    // One hot grant doubles as the ready of each source
    assign s_ready_o = grant_hit ? ({{(`PORT_CNT-1){1'b0}}, 1'b1} << grant_idx) : '0;

    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Port 0 goes first after reset
            last_q    <= port_id_t'(`PORT_CNT - 1);
            m_valid_o <= 1'b0;
        end else begin
            m_valid_o <= grant_hit;
            if (grant_hit) begin
                last_q <= grant_idx;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (grant_hit) begin
            m_inc_o <= s_inc_i[grant_idx];
        end
    end

endmodule

`default_nettype wire

//--- source/frame_fifo.sv
// Store and forward frame FIFO
`timescale 1ns/1ps
`default_nettype none

`include "eth_core_macros.svh"

module frame_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  wire logic                      clk_125mhz,
    input  wire logic                      arst_n_i,
    input  wire logic                      s_valid_i,
    input  wire eth_frame_pkg::axis_beat_t s_beat_i,
    output logic                           m_valid_o,
    output eth_frame_pkg::axis_beat_t      m_beat_o,
    input  wire logic                      m_ready_i,
    input  wire stat_pkg::port_id_t        port_id_i,
    output logic                           stat_valid_o,
    output stat_pkg::stat_inc_t            stat_inc_o,
    input  wire logic                      stat_ready_i
);
    import eth_frame_pkg::*;
    import stat_pkg::*;

    localparam int AW = $clog2(DEPTH);

    // Extra top bit tells full from empty
    typedef logic [AW:0] ptr_t;
    typedef enum logic {WR_ACCEPT, WR_DISCARD} wr_state_e;

    axis_beat_t   mem [DEPTH];
    ptr_t         wr_ptr, commit_ptr, rd_ptr;
    ptr_t         fill, frame_len;
    wr_state_e    wr_state_q, wr_state_d;
    logic         space_ok, wr_en, rewind, commit, ev_bad, ev_drop;
    logic         rd_load;
    stat_amount_t tot_q [`STAT_KIND_CNT];
    stat_amount_t ev_amt [`STAT_KIND_CNT];
    stat_kind_t   sel_kind;
    logic         sel_hit, take;

    function automatic stat_amount_t sat_add(stat_amount_t a, stat_amount_t b);
        logic [`STAT_INC_W:0] sum;
        sum = {1'b0, a} + {1'b0, b};
        return sum[`STAT_INC_W] ? '1 : sum[`STAT_INC_W-1:0];
    endfunction

    assign fill      = wr_ptr - rd_ptr;
    assign space_ok  = fill < ptr_t'(DEPTH);
    // Length of the frame whose last beat is being written now
    assign frame_len = wr_ptr + ptr_t'(1) - commit_ptr;

    always_comb begin
        wr_state_d = wr_state_q;
        wr_en      = 1'b0;
        rewind     = 1'b0;
        commit     = 1'b0;
        ev_bad     = 1'b0;
        ev_drop    = 1'b0;
        if (s_valid_i) begin
            case (wr_state_q)
                WR_ACCEPT: begin
                    if (!space_ok) begin
                        // Frame does not fit, give back what it used
                        rewind = 1'b1;
                        if (s_beat_i.last) begin
                            ev_drop = 1'b1;
                        end else begin
                            wr_state_d = WR_DISCARD;
                        end
                    end else begin
                        wr_en = 1'b1;
                        if (s_beat_i.last && s_beat_i.user) begin
                            rewind = 1'b1;
                            ev_bad = 1'b1;
                        end else if (s_beat_i.last) begin
                            commit = 1'b1;
                        end
                    end
                end
                WR_DISCARD: begin
                    if (s_beat_i.last) begin
                        ev_drop    = 1'b1;
                        wr_state_d = WR_ACCEPT;
                    end
                end
                default: wr_state_d = WR_ACCEPT;
            endcase
        end
    end

    // Only committed data is visible to the read side
    assign rd_load = (rd_ptr != commit_ptr) && (!m_valid_o || m_ready_i);

    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_state_q <= WR_ACCEPT;
            wr_ptr     <= '0;
            commit_ptr <= '0;
            rd_ptr     <= '0;
            m_valid_o  <= 1'b0;
        end else begin
            wr_state_q <= wr_state_d;
            if (rewind) begin
                wr_ptr <= commit_ptr;
            end else if (wr_en) begin
                wr_ptr <= wr_ptr + ptr_t'(1);
            end
            if (commit) begin
                commit_ptr <= wr_ptr + ptr_t'(1);
            end
            if (rd_load) begin
                rd_ptr    <= rd_ptr + ptr_t'(1);
                m_valid_o <= 1'b1;
            end else if (m_ready_i) begin
                m_valid_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (wr_en) begin
            mem[wr_ptr[AW-1:0]] <= s_beat_i;
        end
        if (rd_load) begin
            m_beat_o <= mem[rd_ptr[AW-1:0]];
        end
    end

    always_comb begin
        ev_amt                 = '{default: '0};
        ev_amt[KIND_GOOD_PKT]  = stat_amount_t'(commit);
        ev_amt[KIND_BAD_PKT]   = stat_amount_t'(ev_bad);
        ev_amt[KIND_DROP_PKT]  = stat_amount_t'(ev_drop);
        ev_amt[KIND_GOOD_BYTE] = commit ? stat_amount_t'(frame_len) : '0;
    end

    // Lowest kind index has priority
    always_comb begin
        sel_kind = KIND_GOOD_PKT;
        sel_hit  = 1'b0;
        for (int k = `STAT_KIND_CNT - 1; k >= 0; k--) begin
            if (tot_q[k] != '0) begin
                sel_kind = stat_kind_t'(k);
                sel_hit  = 1'b1;
            end
        end
    end

    assign take = sel_hit && !stat_valid_o;

    // A total moves into the offer register and restarts from zero
    always_ff @(posedge clk_125mhz or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stat_valid_o <= 1'b0;
            for (int k = 0; k < `STAT_KIND_CNT; k++) begin
                tot_q[k] <= '0;
            end
        end else begin
            if (stat_valid_o && stat_ready_i) begin
                stat_valid_o <= 1'b0;
            end else if (take) begin
                stat_valid_o <= 1'b1;
            end
            for (int k = 0; k < `STAT_KIND_CNT; k++) begin
                tot_q[k] <= sat_add((take && sel_kind == k) ? '0 : tot_q[k], ev_amt[k]);
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (take) begin
            stat_inc_o.id  <= stat_id_t'(port_id_i * `STAT_KIND_CNT + sel_kind);
            stat_inc_o.inc <= tot_q[sel_kind];
        end
    end

endmodule

`default_nettype wire

//--- source/stat_pkg.sv
// Statistics types
`default_nettype none

`include "eth_core_macros.svh"

package stat_pkg;

    // Port number, also the upper part of a counter id
    typedef logic [$clog2(`PORT_CNT)-1:0] port_id_t;

    // Counter index, port times kind count plus kind
    typedef logic [$clog2(`PORT_CNT*`STAT_KIND_CNT)-1:0] stat_id_t;

    typedef logic [$clog2(`STAT_KIND_CNT)-1:0] stat_kind_t;
    typedef logic [`STAT_INC_W-1:0]            stat_amount_t;
    typedef logic [`STAT_COUNT_W-1:0]          stat_count_t;

    // Counter kinds within one port
    localparam stat_kind_t KIND_GOOD_PKT  = stat_kind_t'(0);
    localparam stat_kind_t KIND_BAD_PKT   = stat_kind_t'(1);
    localparam stat_kind_t KIND_DROP_PKT  = stat_kind_t'(2);
    localparam stat_kind_t KIND_GOOD_BYTE = stat_kind_t'(3);

    typedef struct packed {
        stat_id_t     id;
        stat_amount_t inc;
    } stat_inc_t;

endpackage

`default_nettype wire

//--- source/eth_frame_pkg.sv
// Byte stream frame types
`default_nettype none

package eth_frame_pkg;

    // One data byte on the stream
    typedef logic [7:0] byte_t;

    // One stream beat
    // user on the last beat flags the whole frame as bad
    typedef struct packed {
        byte_t data;
        logic  last;
        logic  user;
    } axis_beat_t;

endpackage

`default_nettype wire

//--- source/eth_core_macros.svh
// Ethernet loopback core configuration
`ifndef ETH_CORE_MACROS_SVH
`define ETH_CORE_MACROS_SVH

// Number of loopback ports
`define PORT_CNT 4

// Frame FIFO depth in bytes, power of two
`define FIFO_DEPTH 64

// Width of one statistics counter
`define STAT_COUNT_W 32

// Width of one statistics increment
`define STAT_INC_W 16

// Counters kept per port
//   0: forwarded frames
//   1: frames marked bad
//   2: frames dropped on overflow
//   3: bytes of forwarded frames
`define STAT_KIND_CNT 4

`endif
